/* rtl/rv_isa_pkg.sv */
// RV32I instruction formats, load/store opcodes and funct3 codes, and the LSU operation types
package rv_isa_pkg;

  // Major opcodes handled by the LSU
  typedef enum logic [6:0] {
    OP_LOAD  = 7'b0000011,
    OP_STORE = 7'b0100011
  } opcode_e;

  // Load funct3
  localparam logic [2:0] F3_LB  = 3'b000;
  localparam logic [2:0] F3_LH  = 3'b001;
  localparam logic [2:0] F3_LW  = 3'b010;
  localparam logic [2:0] F3_LBU = 3'b100;
  localparam logic [2:0] F3_LHU = 3'b101;

  // Store funct3
  localparam logic [2:0] F3_SB  = 3'b000;
  localparam logic [2:0] F3_SH  = 3'b001;
  localparam logic [2:0] F3_SW  = 3'b010;

  typedef enum logic [1:0] {
    SZ_B = 2'd0,
    SZ_H = 2'd1,
    SZ_W = 2'd2
  } mem_size_e;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_type_t;

  typedef struct packed {
    logic [6:0]  imm_hi;
    logic [4:0]  rs2;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  imm_lo;
    logic [6:0]  opcode;
  } s_type_t;

  // Same 32-bit word, read as a load or as a store
  typedef union packed {
    i_type_t i_view;
    s_type_t s_view;
  } instr_t;

  typedef struct packed {
    logic        valid;
    logic        is_store;
    logic        unsigned_ld;
    logic        illegal;
    mem_size_e   size;
    logic [4:0]  rd;
    logic [31:0] base;       // rs1 value, effective address after execute
    logic [11:0] offset;
    logic [31:0] store_val;
  } mem_op_t;

  typedef struct packed {
    logic [4:0]  rd;
    logic [31:0] data;
    logic        err;
    logic        is_store;
  } wb_result_t;

endpackage

/* rtl/mem_bus_pkg.sv */
// Wishbone classic request and response bundles shared by the LSU master and the data memory
package mem_bus_pkg;

  localparam int XLEN  = 32;
  localparam int SEL_W = XLEN / 8;   // One select per byte lane

  // Master to slave
  typedef struct packed {
    logic             cyc;
    logic             stb;
    logic             we;
    logic [XLEN-1:0]  adr;     // Word aligned byte address
    logic [XLEN-1:0]  dat_w;
    logic [SEL_W-1:0] sel;
  } wb_req_t;

  // Slave to master
  typedef struct packed {
    logic             ack;
    logic [XLEN-1:0]  dat_r;
  } wb_rsp_t;

endpackage

/* rtl/lsu_decode.sv */
// LSU issue stage: accepts one instruction with its operands and registers the decoded memory op
`timescale 1ns/100ps

module lsu_decode (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          issue_valid,
  input  rv_isa_pkg::instr_t            issue_instr,
  input  logic [mem_bus_pkg::XLEN-1:0]  issue_rs1,
  input  logic [mem_bus_pkg::XLEN-1:0]  issue_rs2,
  input  logic                          unit_idle,
  output logic                          issue_ready,
  output rv_isa_pkg::mem_op_t           mem_op
);
  import rv_isa_pkg::*;

  logic       accept;
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       is_load;
  logic       is_store;
  logic       f3_ok;
  mem_size_e  size;
  logic       valid_q;
  mem_op_t    op_q;

  // Block a second issue in the cycle right after acceptance
  assign issue_ready = unit_idle && !valid_q;
  assign accept      = issue_valid && issue_ready;

  assign opcode   = issue_instr.i_view.opcode;   // Same bits in both views
  assign funct3   = issue_instr.i_view.funct3;
  assign is_load  = (opcode == OP_LOAD);
  assign is_store = (opcode == OP_STORE);

  always_comb begin
    size  = SZ_W;
    f3_ok = 1'b0;
    if (is_store) begin
      case (funct3)
        F3_SB: begin size = SZ_B; f3_ok = 1'b1; end
        F3_SH: begin size = SZ_H; f3_ok = 1'b1; end
        F3_SW: begin size = SZ_W; f3_ok = 1'b1; end
        default: f3_ok = 1'b0;
      endcase
    end else if (is_load) begin
      case (funct3)
        F3_LB, F3_LBU: begin size = SZ_B; f3_ok = 1'b1; end
        F3_LH, F3_LHU: begin size = SZ_H; f3_ok = 1'b1; end
        F3_LW:         begin size = SZ_W; f3_ok = 1'b1; end
        default: f3_ok = 1'b0;
      endcase
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= accept;   // One-cycle pulse into execute
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      op_q.valid       <= 1'b1;
      op_q.is_store    <= is_store;
      op_q.unsigned_ld <= is_load && funct3[2];
      op_q.illegal     <= !(is_load || is_store) || !f3_ok;
      op_q.size        <= size;
      op_q.rd          <= is_store ? 5'd0 : issue_instr.i_view.rd;   // Stores write no register
      op_q.base        <= issue_rs1;
      op_q.offset      <= is_store ? {issue_instr.s_view.imm_hi, issue_instr.s_view.imm_lo}
                                   : issue_instr.i_view.imm;
      op_q.store_val   <= issue_rs2;
    end
  end

  always_comb begin
    mem_op       = op_q;
    mem_op.valid = valid_q;
  end

endmodule

/* rtl/lsu_execute.sv */
// LSU execute stage: effective address, alignment check, byte lanes and the Wishbone master cycle
`timescale 1ns/100ps

module lsu_execute (
  input  logic                          clk,
  input  logic                          rst,
  input  rv_isa_pkg::mem_op_t           mem_op,
  output mem_bus_pkg::wb_req_t          bus_req,
  input  mem_bus_pkg::wb_rsp_t          bus_rsp,
  output logic                          done,
  output rv_isa_pkg::mem_op_t           ex_out,
  output logic [mem_bus_pkg::XLEN-1:0]  ex_data,
  output logic                          ex_err
);
  import rv_isa_pkg::*;
  import mem_bus_pkg::*;

  logic [XLEN-1:0]  eff_addr;
  logic             misaligned;
  logic             bad_op;
  logic [XLEN-1:0]  lane_data;
  logic [SEL_W-1:0] lane_sel;
  logic             bus_busy;   // Drives both cyc and stb
  logic             bus_ack;
  logic             err_done;
  logic             active;
  logic             we_q;
  logic [XLEN-1:0]  adr_q;
  logic [XLEN-1:0]  dat_q;
  logic [SEL_W-1:0] sel_q;
  mem_op_t          op_q;

  assign eff_addr = mem_op.base + {{(XLEN-12){mem_op.offset[11]}}, mem_op.offset};

  always_comb begin
    case (mem_op.size)
      SZ_B: begin
        misaligned = 1'b0;
        lane_data  = {4{mem_op.store_val[7:0]}};
        lane_sel   = 4'b0001 << eff_addr[1:0];
      end
      SZ_H: begin
        misaligned = eff_addr[0];
        lane_data  = {2{mem_op.store_val[15:0]}};
        lane_sel   = 4'b0011 << eff_addr[1:0];
      end
      default: begin
        misaligned = (eff_addr[1:0] != 2'b00);
        lane_data  = mem_op.store_val;
        lane_sel   = 4'b1111;
      end
    endcase
  end

  assign bad_op  = mem_op.illegal || misaligned;
  assign bus_ack = bus_busy && bus_rsp.ack;
  assign done    = bus_ack || err_done;   // Ack cycle, or the cycle after a rejected op
  assign ex_data = bus_rsp.dat_r;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      bus_busy <= 1'b0;
      err_done <= 1'b0;
      active   <= 1'b0;
      ex_err   <= 1'b0;
    end else begin
      err_done <= 1'b0;
      if (mem_op.valid) begin
        active   <= 1'b1;
        bus_busy <= !bad_op;   // Rejected ops never touch the bus
        err_done <= bad_op;
        ex_err   <= bad_op;
      end else if (bus_ack || err_done) begin
        active   <= 1'b0;
        bus_busy <= 1'b0;
      end
    end
  end

  // Request fields stay put until ack
  always_ff @(posedge clk) begin
    if (mem_op.valid) begin
      we_q        <= mem_op.is_store;
      adr_q       <= {eff_addr[XLEN-1:2], 2'b00};
      dat_q       <= lane_data;
      sel_q       <= lane_sel;
      op_q        <= mem_op;
      op_q.base   <= eff_addr;   // Low bits pick the load lanes later
      op_q.offset <= '0;
    end
  end

  always_comb begin
    bus_req.cyc   = bus_busy;
    bus_req.stb   = bus_busy;
    bus_req.we    = we_q;
    bus_req.adr   = adr_q;
    bus_req.dat_w = dat_q;
    bus_req.sel   = sel_q;
    ex_out        = op_q;
    ex_out.valid  = active;
  end

endmodule

/* rtl/lsu_result.sv */
// LSU writeback stage: aligns and extends load data and pulses the result to the register file
`timescale 1ns/100ps

module lsu_result (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          done,
  input  rv_isa_pkg::mem_op_t           ex_out,
  input  logic [mem_bus_pkg::XLEN-1:0]  ex_data,
  input  logic                          ex_err,
  output logic                          wb_valid,
  output rv_isa_pkg::wb_result_t        wb,
  output logic                          unit_idle
);
  import rv_isa_pkg::*;
  import mem_bus_pkg::*;

  logic [XLEN-1:0] shifted;
  logic [XLEN-1:0] load_val;

  // Bring the addressed byte or halfword down to bit 0
  assign shifted = ex_data >> {ex_out.base[1:0], 3'b000};

  always_comb begin
    case (ex_out.size)
      SZ_B: begin
        if (ex_out.unsigned_ld) load_val = {24'd0, shifted[7:0]};
        else                    load_val = {{24{shifted[7]}}, shifted[7:0]};
      end
      SZ_H: begin
        if (ex_out.unsigned_ld) load_val = {16'd0, shifted[15:0]};
        else                    load_val = {{16{shifted[15]}}, shifted[15:0]};
      end
      default: load_val = shifted;
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wb_valid <= 1'b0;
    end else begin
      wb_valid <= done;
    end
  end

  always_ff @(posedge clk) begin
    if (done) begin
      wb.rd       <= ex_out.rd;
      wb.data     <= (ex_out.is_store || ex_err) ? '0 : load_val;
      wb.err      <= ex_err;
      wb.is_store <= ex_out.is_store;
    end
  end

  // Busy from execute start until the writeback pulse has gone out
  assign unit_idle = !(ex_out.valid || wb_valid);

endmodule

/* rtl/data_sram.sv */
// Wishbone classic data memory with byte selects, answering each request one clock later
`timescale 1ns/100ps

module data_sram #(
  parameter int unsigned                   MEM_WORDS = 1024,
  parameter logic [mem_bus_pkg::XLEN-1:0]  ADDR_BASE = '0
) (
  input  logic                  clk,
  input  logic                  rst,
  input  mem_bus_pkg::wb_req_t  bus_req,
  output mem_bus_pkg::wb_rsp_t  bus_rsp
);
  import mem_bus_pkg::*;

  localparam int IDX_W = $clog2(MEM_WORDS);

  logic [XLEN-1:0]  mem [MEM_WORDS];
  logic [XLEN-1:0]  word_off;
  logic [IDX_W-1:0] idx;
  logic             new_req;
  logic             ack_q;
  logic [XLEN-1:0]  rdata_q;

  assign word_off = bus_req.adr - ADDR_BASE;
  assign idx      = word_off[IDX_W+1:2];   // Byte offset to word index

  // A strobe not yet acked is a fresh request
  assign new_req = bus_req.cyc && bus_req.stb && !ack_q;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= new_req;   // Single-cycle ack
    end
  end

  always_ff @(posedge clk) begin
    if (new_req) begin
      if (bus_req.we) begin
        for (int i = 0; i < SEL_W; i++) begin
          if (bus_req.sel[i]) begin
            mem[idx][8*i +: 8] <= bus_req.dat_w[8*i +: 8];
          end
        end
      end
      rdata_q <= mem[idx];   // Whole word, master picks the lanes
    end
  end

  assign bus_rsp.ack   = ack_q;
  assign bus_rsp.dat_r = rdata_q;

endmodule

/* rtl/lsu_top.sv */
// Load/store unit top: decode, execute and writeback stages around the Wishbone data memory
`timescale 1ns/100ps

module lsu_top #(
  parameter int unsigned                   MEM_WORDS = 1024,
  parameter logic [mem_bus_pkg::XLEN-1:0]  ADDR_BASE = '0
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          issue_valid,
  input  rv_isa_pkg::instr_t            issue_instr,
  input  logic [mem_bus_pkg::XLEN-1:0]  issue_rs1,
  input  logic [mem_bus_pkg::XLEN-1:0]  issue_rs2,
  output logic                          issue_ready,
  output logic                          wb_valid,
  output rv_isa_pkg::wb_result_t        wb
);
  import rv_isa_pkg::*;
  import mem_bus_pkg::*;

  mem_op_t         mem_op;
  mem_op_t         ex_out;
  wb_req_t         bus_req;
  wb_rsp_t         bus_rsp;
  logic [XLEN-1:0] ex_data;
  logic            ex_err;
  logic            done;
  logic            unit_idle;

  lsu_decode decode_i (
    .clk         (clk),
    .rst         (rst),
    .issue_valid (issue_valid),
    .issue_instr (issue_instr),
    .issue_rs1   (issue_rs1),
    .issue_rs2   (issue_rs2),
    .unit_idle   (unit_idle),
    .issue_ready (issue_ready),
    .mem_op      (mem_op)
  );

  lsu_execute execute_i (
    .clk     (clk),
    .rst     (rst),
    .mem_op  (mem_op),
    .bus_req (bus_req),
    .bus_rsp (bus_rsp),
    .done    (done),
    .ex_out  (ex_out),
    .ex_data (ex_data),
    .ex_err  (ex_err)
  );

  lsu_result result_i (
    .clk       (clk),
    .rst       (rst),
    .done      (done),
    .ex_out    (ex_out),
    .ex_data   (ex_data),
    .ex_err    (ex_err),
    .wb_valid  (wb_valid),
    .wb        (wb),
    .unit_idle (unit_idle)
  );

  data_sram #(
    .MEM_WORDS (MEM_WORDS),
    .ADDR_BASE (ADDR_BASE)
  ) sram_i (
    .clk     (clk),
    .rst     (rst),
    .bus_req (bus_req),
    .bus_rsp (bus_rsp)
  );

endmodule

/* test/lsu_bus_chk.sv */
// Wishbone classic protocol assertions, bound into the data memory to watch its bus port
`timescale 1ns/100ps

module lsu_bus_chk (
  input logic                  clk,
  input logic                  rst,
  input mem_bus_pkg::wb_req_t  bus_req,
  input mem_bus_pkg::wb_rsp_t  bus_rsp
);

  // A strobe is only legal inside a cycle
  stb_in_cyc: assert property (@(posedge clk) disable iff (rst)
    bus_req.stb |-> bus_req.cyc)
    else $error("bus stb high while cyc is low");

  // One clock of latency from a fresh strobe to ack
  ack_after_stb: assert property (@(posedge clk) disable iff (rst)
    (bus_req.stb && !bus_rsp.ack) |=> bus_rsp.ack)
    else $error("bus ack did not follow stb after one cycle");

  ack_one_cycle: assert property (@(posedge clk) disable iff (rst)
    bus_rsp.ack |=> !bus_rsp.ack)
    else $error("bus ack held for more than one cycle");

  adr_held: assert property (@(posedge clk) disable iff (rst)
    (bus_req.stb && !bus_rsp.ack) |=> $stable(bus_req.adr))
    else $error("bus adr changed while waiting for ack");

endmodule

bind data_sram lsu_bus_chk bus_chk_i (
  .clk     (clk),
  .rst     (rst),
  .bus_req (bus_req),
  .bus_rsp (bus_rsp)
);

/* test/lsu_monitor.sv */
// Testbench scoreboard: predicts each writeback from a byte memory model and checks the LSU output
`timescale 1ns/100ps

module lsu_monitor (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    issue_valid,
  input  logic                    issue_ready,
  input  rv_isa_pkg::instr_t      issue_instr,
  input  logic [31:0]             issue_rs1,
  input  logic [31:0]             issue_rs2,
  input  logic [127:0]            test_name,
  input  logic                    wb_valid,
  input  rv_isa_pkg::wb_result_t  wb,
  output int                      tests_done,
  output int                      tests_failed,
  output int                      stray_errors
);
  import rv_isa_pkg::*;

  localparam int WB_LIMIT   = 6;   // Cycles allowed from accept to writeback
  localparam int ACCESS_LAT = 3;   // Accept to writeback through the bus
  localparam int REJECT_LAT = 2;   // Rejected op skips the bus

  logic [7:0]   model [4096];
  logic         pending;
  int           wait_cycles;
  int           exp_lat;
  wb_result_t   exp_wb;
  logic [127:0] exp_name;

  // Expected writeback from the ISA rules, store bytes go into the model
  task automatic predict(input logic [31:0] instr, input logic [31:0] rs1,
                         input logic [31:0] rs2);
    logic [6:0]  opc;
    logic [2:0]  f3;
    logic [31:0] imm;
    logic [31:0] addr;
    logic [31:0] word;
    logic        legal;
    logic        store;
    int          nbytes;
    int          base_idx;
    opc   = instr[6:0];
    f3    = instr[14:12];
    store = (opc == 7'b0100011);
    if (store) begin
      imm   = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      legal = (f3 <= 3'd2);
    end else begin
      imm   = {{20{instr[31]}}, instr[31:20]};
      legal = (opc == 7'b0000011) &&
              (f3 == 3'd0 || f3 == 3'd1 || f3 == 3'd2 || f3 == 3'd4 || f3 == 3'd5);
    end
    addr   = rs1 + imm;
    nbytes = 1 << f3[1:0];
    if ((f3[1:0] == 2'd1 && addr[0]) || (f3[1:0] == 2'd2 && addr[1:0] != 2'd0)) begin
      legal = 1'b0;   // Misaligned half or word
    end
    base_idx        = int'(addr[11:0]);
    word            = '0;
    exp_wb.rd       = store ? 5'd0 : instr[11:7];
    exp_wb.is_store = store;
    exp_wb.err      = !legal;
    exp_wb.data     = '0;
    exp_lat         = legal ? ACCESS_LAT : REJECT_LAT;
    if (legal && store) begin
      for (int i = 0; i < nbytes; i++) model[base_idx + i] = rs2[8*i +: 8];
    end else if (legal) begin
      for (int i = 0; i < nbytes; i++) word[8*i +: 8] = model[base_idx + i];
      if (nbytes == 1 && !f3[2]) word = {{24{word[7]}}, word[7:0]};
      else if (nbytes == 2 && !f3[2]) word = {{16{word[15]}}, word[15:0]};
      exp_wb.data = word;
    end
  endtask

  task automatic compare_result();
    logic ok;
    ok = 1'b1;
    if (wait_cycles != exp_lat) begin
      $display("MISMATCH %s wb_valid latency expected %h actual %h", exp_name, exp_lat,
               wait_cycles);
      ok = 1'b0;
    end
    if (wb.rd !== exp_wb.rd) begin
      $display("MISMATCH %s wb.rd expected %h actual %h", exp_name, exp_wb.rd, wb.rd);
      ok = 1'b0;
    end
    if (wb.data !== exp_wb.data) begin
      $display("MISMATCH %s wb.data expected %h actual %h", exp_name, exp_wb.data, wb.data);
      ok = 1'b0;
    end
    if (wb.err !== exp_wb.err) begin
      $display("MISMATCH %s wb.err expected %h actual %h", exp_name, exp_wb.err, wb.err);
      ok = 1'b0;
    end
    if (wb.is_store !== exp_wb.is_store) begin
      $display("MISMATCH %s wb.is_store expected %h actual %h", exp_name, exp_wb.is_store,
               wb.is_store);
      ok = 1'b0;
    end
    if (!ok) tests_failed++;
    $display("test %0d %s %s", tests_done, exp_name, ok ? "passed" : "FAILED");
    tests_done++;
  endtask

  always @(posedge clk or posedge rst) begin
    if (rst) begin
      pending      = 1'b0;
      wait_cycles  = 0;
      exp_lat      = 0;
      tests_done   = 0;
      tests_failed = 0;
      stray_errors = 0;
    end else begin
      // Unit must stay busy until the writeback pulse is over
      if (pending && issue_ready) begin
        $display("issue_ready high while %s was still in flight", exp_name);
        stray_errors++;
      end
      if (wb_valid) begin
        if (!pending) begin
          $display("Writeback pulse for rd %0d arrived with no instruction in flight", wb.rd);
          stray_errors++;
        end else begin
          compare_result();
          pending = 1'b0;
        end
      end else if (pending) begin
        wait_cycles++;
        if (wait_cycles > WB_LIMIT) begin
          $display("No writeback for test %s within %0d cycles", exp_name, WB_LIMIT);
          tests_failed++;
          tests_done++;
          pending = 1'b0;
        end
      end
      if (issue_valid && issue_ready) begin
        if (pending) begin
          $display("Second instruction accepted while %s was still in flight", exp_name);
          stray_errors++;
        end
        predict(issue_instr, issue_rs1, issue_rs2);
        exp_name    = test_name;
        pending     = 1'b1;
        wait_cycles = 0;
      end
    end
  end

endmodule

/* test/lsu_tb.sv */
// Testbench top for the LSU: clock, reset, stimulus table, issue loop, watchdog and final verdict
`timescale 1ns/100ps

module lsu_tb;
  import rv_isa_pkg::*;

  localparam int          NUM_ROWS       = 30;
  localparam int          RESET_CYCLES   = 16;
  localparam int          TIMEOUT_CYCLES = NUM_ROWS * 10 + 100;
  localparam logic [31:0] SEED           = 32'h5f535f6f;

  // One stimulus row, the label is space padded text
  typedef struct packed {
    logic [31:0]  instr;
    logic [31:0]  rs1;
    logic [31:0]  rs2;
    logic [127:0] name;
  } row_t;

  row_t         rows [NUM_ROWS];
  logic         clk;
  logic         rst;
  logic         issue_valid;
  logic         issue_ready;
  instr_t       issue_instr;
  logic [31:0]  issue_rs1;
  logic [31:0]  issue_rs2;
  logic         wb_valid;
  wb_result_t   wb;
  logic [127:0] test_name;
  int           tests_done;
  int           tests_failed;
  int           stray_errors;

  lsu_top #(
    .MEM_WORDS (1024),
    .ADDR_BASE (32'h0)
  ) dut_i (
    .clk         (clk),
    .rst         (rst),
    .issue_valid (issue_valid),
    .issue_instr (issue_instr),
    .issue_rs1   (issue_rs1),
    .issue_rs2   (issue_rs2),
    .issue_ready (issue_ready),
    .wb_valid    (wb_valid),
    .wb          (wb)
  );

  lsu_monitor mon_i (
    .clk          (clk),
    .rst          (rst),
    .issue_valid  (issue_valid),
    .issue_ready  (issue_ready),
    .issue_instr  (issue_instr),
    .issue_rs1    (issue_rs1),
    .issue_rs2    (issue_rs2),
    .test_name    (test_name),
    .wb_valid     (wb_valid),
    .wb           (wb),
    .tests_done   (tests_done),
    .tests_failed (tests_failed),
    .stray_errors (stray_errors)
  );

  // I-type load, rs1 field is x1
  function automatic logic [31:0] encode_load(input logic [2:0] f3, input logic [4:0] rd,
                                              input logic [11:0] imm);
    return {imm, 5'd1, f3, rd, 7'b0000011};
  endfunction

  // S-type store, rs1 is x1 and rs2 is x2
  function automatic logic [31:0] encode_store(input logic [2:0] f3, input logic [11:0] imm);
    return {imm[11:5], 5'd2, 5'd1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic row_t make_row(input logic [31:0] instr, input logic [31:0] rs1,
                                    input logic [31:0] rs2, input string label);
    row_t r;
    r.instr = instr;
    r.rs1   = rs1;
    r.rs2   = rs2;
    r.name  = {16{8'h20}};
    for (int i = 0; i < label.len() && i < 16; i++) r.name = {r.name[119:0], label.getc(i)};
    return r;
  endfunction

  task automatic build_table();
    logic [31:0] base_a;
    logic [31:0] base_b;
    // Random word bases, 32 above the target so the offset is negative
    base_a = 32'h420 + (($urandom % 64) << 2);
    base_b = 32'h420 + (($urandom % 64) << 2);
    rows[0]  = make_row(encode_store(3'd2, 12'd0), 32'h100, 32'hdeadbeef, "sw_word");
    rows[1]  = make_row(encode_load(3'd2, 5'd5, 12'd0), 32'h100, 32'h0, "lw_word");
    rows[2]  = make_row(encode_store(3'd2, 12'd4), 32'h200, 32'h11223344, "sw_base");
    rows[3]  = make_row(encode_store(3'd0, 12'd5), 32'h200, 32'h000000a5, "sb_lane1");
    rows[4]  = make_row(encode_store(3'd1, 12'd6), 32'h200, 32'h0000beef, "sh_lane23");
    rows[5]  = make_row(encode_load(3'd2, 5'd6, 12'd4), 32'h200, 32'h0, "lw_merged");
    // Every byte differs and has its top bit set
    rows[6]  = make_row(encode_store(3'd2, 12'd0), 32'h300, 32'h80ff9181, "sw_signs");
    rows[7]  = make_row(encode_load(3'd0, 5'd7, 12'd0), 32'h300, 32'h0, "lb_off0");
    rows[8]  = make_row(encode_load(3'd0, 5'd23, 12'd1), 32'h300, 32'h0, "lb_off1");
    rows[9]  = make_row(encode_load(3'd0, 5'd9, 12'd2), 32'h300, 32'h0, "lb_off2");
    rows[10] = make_row(encode_load(3'd0, 5'd11, 12'd3), 32'h300, 32'h0, "lb_off3");
    rows[11] = make_row(encode_load(3'd4, 5'd12, 12'd0), 32'h300, 32'h0, "lbu_off0");
    rows[12] = make_row(encode_load(3'd4, 5'd8, 12'd1), 32'h300, 32'h0, "lbu_off1");
    rows[13] = make_row(encode_load(3'd4, 5'd24, 12'd2), 32'h300, 32'h0, "lbu_off2");
    rows[14] = make_row(encode_load(3'd4, 5'd10, 12'd3), 32'h300, 32'h0, "lbu_off3");
    rows[15] = make_row(encode_load(3'd1, 5'd13, 12'd0), 32'h300, 32'h0, "lh_off0");
    rows[16] = make_row(encode_load(3'd1, 5'd15, 12'd2), 32'h300, 32'h0, "lh_off2");
    rows[17] = make_row(encode_load(3'd5, 5'd25, 12'd0), 32'h300, 32'h0, "lhu_off0");
    rows[18] = make_row(encode_load(3'd5, 5'd14, 12'd2), 32'h300, 32'h0, "lhu_off2");
    rows[19] = make_row(encode_load(3'd2, 5'd16, 12'd1), 32'h100, 32'h0, "lw_misalign");
    rows[20] = make_row(encode_store(3'd1, 12'd1), 32'h300, 32'h00001234, "sh_misalign");
    rows[21] = make_row(encode_store(3'd2, 12'd2), 32'h300, 32'hcafef00d, "sw_misalign");
    rows[22] = make_row(encode_load(3'd1, 5'd17, 12'd3), 32'h300, 32'h0, "lh_misalign");
    rows[23] = make_row(encode_load(3'd2, 5'd18, 12'd0), 32'h300, 32'h0, "lw_unchanged");
    rows[24] = make_row({12'd5, 5'd1, 3'd0, 5'd19, 7'b0010011}, 32'h300, 32'h0, "bad_opcode");
    rows[25] = make_row(encode_load(3'd3, 5'd20, 12'd0), 32'h300, 32'h0, "bad_funct3");
    rows[26] = make_row(encode_store(3'd2, 12'hfe0), base_a, $urandom, "sw_neg_a");
    rows[27] = make_row(encode_load(3'd2, 5'd21, 12'hfe0), base_a, 32'h0, "lw_neg_a");
    rows[28] = make_row(encode_store(3'd2, 12'hfe0), base_b, $urandom, "sw_neg_b");
    rows[29] = make_row(encode_load(3'd2, 5'd22, 12'hfe0), base_b, 32'h0, "lw_neg_b");
  endtask

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Watchdog
  initial begin
    repeat (RESET_CYCLES + TIMEOUT_CYCLES) @(posedge clk);
    $display("Timeout after %0d cycles with %0d of %0d tests finished",
             TIMEOUT_CYCLES, tests_done, NUM_ROWS);
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    rst         = 1'b1;
    issue_valid = 1'b0;
    issue_instr = '0;
    issue_rs1   = '0;
    issue_rs2   = '0;
    test_name   = '0;
    void'($urandom(SEED));
    build_table();
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (int i = 0; i < NUM_ROWS; i++) begin
      while (!issue_ready) @(negedge clk);
      issue_valid = 1'b1;
      issue_instr = rows[i].instr;
      issue_rs1   = rows[i].rs1;
      issue_rs2   = rows[i].rs2;
      test_name   = rows[i].name;
      @(negedge clk);
      issue_valid = 1'b0;
    end
    while (tests_done < NUM_ROWS) @(negedge clk);
    repeat (4) @(negedge clk);   // Room for a stray late pulse
    $display("tests %0d, passed %0d, failed %0d, other errors %0d",
             tests_done, tests_done - tests_failed, tests_failed, stray_errors);
    if (tests_failed == 0 && stray_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

/* src.f */
rtl/rv_isa_pkg.sv
rtl/mem_bus_pkg.sv
rtl/lsu_decode.sv
rtl/lsu_execute.sv
rtl/lsu_result.sv
rtl/data_sram.sv
rtl/lsu_top.sv
test/lsu_bus_chk.sv
test/lsu_monitor.sv
test/lsu_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the LSU testbench with Verilator, runs it and checks the verdict

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f src.f --top-module lsu_tb -o lsu_sim; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/lsu_sim)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "SIMULATION PASSED"; then
  exit 0
fi
exit 1
